// File: run.sh
#!/bin/sh
# Build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module coreTb -o coreSim

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/coreSim

// File: source/computeCore.sv
// Five-stage integer core
`timescale 1ns/1ns

module computeCore import corePkg::*; #(
    parameter logic [XLEN-1:0] ResetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    output logic [XLEN-1:0] extPc,
    input  instrWord_t      extInstr,
    output logic            extMemEn,
    output logic            extMemWriteEn,
    output logic [XLEN-1:0] extMemAdr,
    output logic [XLEN-1:0] extMemWriteData,
    input  logic [XLEN-1:0] extMemReadData
);

    // Fetch
    logic                 fetchValid;
    logic                 stall;

    // Decode
    instrWord_t           decInstr;
    logic                 decValid;
    logic [REG_ADR_W-1:0] decRs1Adr;
    logic [REG_ADR_W-1:0] decRs2Adr;
    logic [REG_ADR_W-1:0] decRdAdr;
    logic [XLEN-1:0]      decOperandA;
    logic [XLEN-1:0]      decOperandB;
    logic [XLEN-1:0]      decStoreData;
    aluOp_t               decAluOp;
    logic                 decMemEn;
    logic                 decMemWriteEn;
    logic                 decRegWrite;
    logic                 decUseImm;
    fwdSrc_t              decFwdA;
    fwdSrc_t              decFwdB;

    // Compute
    logic [XLEN-1:0]      exOperandA;
    logic [XLEN-1:0]      exOperandB;
    logic [XLEN-1:0]      exStoreData;
    logic                 exUseImm;
    aluOp_t               exAluOp;
    fwdSrc_t              exFwdA;
    fwdSrc_t              exFwdB;
    logic [REG_ADR_W-1:0] exRdAdr;
    logic                 exMemEn;
    logic                 exMemWriteEn;
    logic                 exRegWrite;
    logic [XLEN-1:0]      exResult;
    logic [XLEN-1:0]      exMemWriteData;

    // Memory
    logic [XLEN-1:0]      memResult;
    logic [XLEN-1:0]      memWriteData;
    logic [REG_ADR_W-1:0] memRdAdr;
    logic                 memAccessEn;
    logic                 memWriteEn;
    logic                 memRegWrite;

    // Writeback
    logic [XLEN-1:0]      wbComputeResult;
    logic [XLEN-1:0]      wbLoadData;
    logic [XLEN-1:0]      wbResult;
    logic [REG_ADR_W-1:0] wbRdAdr;
    logic                 wbRegWrite;
    logic                 wbLoad;

    fetchStage #(.ResetPc(ResetPc)) fetch (
        .clk, .arstN, .stall,
        .pc(extPc),
        .fetchValid
    );

    // Fetch to decode register holds while stalled
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decInstr <= '0;
            decValid <= 1'b0;
        end else if (!stall) begin
            decInstr <= extInstr;
            decValid <= fetchValid;
        end
    end

    decodeStage decode (
        .clk, .arstN,
        .instr(decInstr), .instrValid(decValid),
        .wbWriteEn(wbRegWrite), .wbAdr(wbRdAdr), .wbData(wbResult),
        .rs1Adr(decRs1Adr), .rs2Adr(decRs2Adr), .rdAdr(decRdAdr),
        .operandA(decOperandA), .operandB(decOperandB), .storeData(decStoreData),
        .aluOp(decAluOp),
        .memEn(decMemEn), .memWriteEn(decMemWriteEn), .regWrite(decRegWrite)
    );

    assign decUseImm = decInstr.r.opcode != OP_REG;

    hazardUnit hazard (
        .rs1Adr(decRs1Adr), .rs2Adr(decRs2Adr),
        .exRdAdr, .exRegWrite, .exMemEn, .exMemWriteEn,
        .memRdAdr, .memRegWrite,
        .fwdA(decFwdA), .fwdB(decFwdB),
        .stall
    );

    // Decode to compute; a stall turns it into a bubble
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exMemEn      <= 1'b0;
            exMemWriteEn <= 1'b0;
            exRegWrite   <= 1'b0;
        end else begin
            exMemEn      <= decMemEn && !stall;
            exMemWriteEn <= decMemWriteEn && !stall;
            exRegWrite   <= decRegWrite && !stall;
        end
    end

    always_ff @(posedge clk) begin
        exOperandA  <= decOperandA;
        exOperandB  <= decOperandB;
        exStoreData <= decStoreData;
        exUseImm    <= decUseImm;
        exAluOp     <= decAluOp;
        exFwdA      <= decFwdA;
        exFwdB      <= decFwdB;
        exRdAdr     <= decRdAdr;
    end

    executeStage execute (
        .operandA(exOperandA), .operandB(exOperandB), .storeData(exStoreData),
        .useImm(exUseImm), .aluOp(exAluOp),
        .fwdA(exFwdA), .fwdB(exFwdB),
        .memResult, .wbResult,
        .result(exResult), .memWriteData(exMemWriteData)
    );

    // Compute to memory
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memAccessEn <= 1'b0;
            memWriteEn  <= 1'b0;
            memRegWrite <= 1'b0;
        end else begin
            memAccessEn <= exMemEn;
            memWriteEn  <= exMemWriteEn;
            memRegWrite <= exRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        memResult    <= exResult;
        memWriteData <= exMemWriteData;
        memRdAdr     <= exRdAdr;
    end

    // Data port sees one access per load or store
    assign extMemEn        = memAccessEn;
    assign extMemWriteEn   = memWriteEn;
    assign extMemAdr       = memResult;
    assign extMemWriteData = memWriteData;

    // Memory to writeback
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbRegWrite <= 1'b0;
            wbLoad     <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
            wbLoad     <= memAccessEn && !memWriteEn;
        end
    end

    always_ff @(posedge clk) begin
        wbComputeResult <= memResult;
        wbLoadData      <= extMemReadData;
        wbRdAdr         <= memRdAdr;
    end

    assign wbResult = wbLoad ? wbLoadData : wbComputeResult;

    // Only word accesses reach the data port
    wordAligned: assert property (
        @(posedge clk) disable iff (!arstN)
        extMemEn |-> extMemAdr[1:0] == 2'b00
    ) else $error("computeCore: misaligned data access");

endmodule

// File: source/corePkg.sv
// Core shared definitions
package corePkg;

    localparam int XLEN = 32;
    localparam int REG_ADR_W = 5;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } aluOp_t;

    // Operand source seen by the compute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSrc_t;

    // funct3 / funct7 encodings
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    // One instruction word, three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [REG_ADR_W-1:0] rs2;
            logic [REG_ADR_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_ADR_W-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm12;
            logic [REG_ADR_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_ADR_W-1:0] rd;
            logic [6:0]           opcode;
        } i;
        struct packed {
            logic [6:0]           immHigh;
            logic [REG_ADR_W-1:0] rs2;
            logic [REG_ADR_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           immLow;
            logic [6:0]           opcode;
        } s;
    } instrWord_t;

endpackage

// File: source/decodeStage.sv
// Instruction decode and register read
`timescale 1ns/1ns

module decodeStage import corePkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  instrWord_t           instr,
    input  logic                 instrValid,
    input  logic                 wbWriteEn,
    input  logic [REG_ADR_W-1:0] wbAdr,
    input  logic [XLEN-1:0]      wbData,
    output logic [REG_ADR_W-1:0] rs1Adr,
    output logic [REG_ADR_W-1:0] rs2Adr,
    output logic [REG_ADR_W-1:0] rdAdr,
    output logic [XLEN-1:0]      operandA,
    output logic [XLEN-1:0]      operandB,
    output logic [XLEN-1:0]      storeData,
    output aluOp_t               aluOp,
    output logic                 memEn,
    output logic                 memWriteEn,
    output logic                 regWrite
);

    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic            known;
    logic            isLoad;
    logic            isStore;
    logic            isImmOp;
    logic            active;

    regFile regs (
        .clk, .arstN,
        .rs1Adr, .rs2Adr,
        .rs1Data, .rs2Data,
        .writeEn(wbWriteEn),
        .writeAdr(wbAdr),
        .writeData(wbData)
    );

    assign rs1Adr = instr.r.rs1;
    assign rs2Adr = instr.r.rs2;
    assign rdAdr  = instr.r.rd;

    assign immI = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
    assign immS = {{(XLEN-12){instr.s.immHigh[6]}}, instr.s.immHigh, instr.s.immLow};

    always_comb begin
        known   = 1'b0;
        isLoad  = 1'b0;
        isStore = 1'b0;
        isImmOp = 1'b0;
        aluOp   = ALU_ADD;
        case (instr.r.opcode)
            OP_REG: begin
                // funct7 alt only legal for SUB and SRA
                known = (instr.r.funct7 == F7_BASE) ||
                        (instr.r.funct7 == F7_ALT &&
                         (instr.r.funct3 == F3_ADD_SUB || instr.r.funct3 == F3_SRL_SRA));
                case (instr.r.funct3)
                    F3_ADD_SUB: aluOp = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    F3_SLL:     aluOp = ALU_SLL;
                    F3_SLT:     aluOp = ALU_SLT;
                    F3_SLTU:    aluOp = ALU_SLTU;
                    F3_XOR:     aluOp = ALU_XOR;
                    F3_SRL_SRA: aluOp = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:      aluOp = ALU_OR;
                    default:    aluOp = ALU_AND;
                endcase
            end
            OP_IMM: begin
                isImmOp = 1'b1;
                known   = 1'b1;
                case (instr.i.funct3)
                    F3_ADD_SUB: aluOp = ALU_ADD;
                    F3_SLT:     aluOp = ALU_SLT;
                    F3_XOR:     aluOp = ALU_XOR;
                    F3_OR:      aluOp = ALU_OR;
                    F3_AND:     aluOp = ALU_AND;
                    default:    known = 1'b0;
                endcase
            end
            OP_LOAD: begin
                isLoad = 1'b1;
                known  = instr.i.funct3 == F3_WORD;
            end
            OP_STORE: begin
                isStore = 1'b1;
                known   = instr.s.funct3 == F3_WORD;
            end
            default: known = 1'b0;
        endcase
    end

    // Anything not recognised leaves as a bubble
    assign active     = instrValid && known;
    assign memEn      = active && (isLoad || isStore);
    assign memWriteEn = active && isStore;
    assign regWrite   = active && !isStore && rdAdr != '0;

    assign operandA  = rs1Data;
    assign operandB  = isStore ? immS : (isImmOp || isLoad) ? immI : rs2Data;
    assign storeData = rs2Data;

endmodule

// File: source/executeStage.sv
// Forwarding muxes and ALU
`timescale 1ns/1ns

module executeStage import corePkg::*; (
    input  logic [XLEN-1:0] operandA,
    input  logic [XLEN-1:0] operandB,
    input  logic [XLEN-1:0] storeData,
    input  logic            useImm,
    input  aluOp_t          aluOp,
    input  fwdSrc_t         fwdA,
    input  fwdSrc_t         fwdB,
    input  logic [XLEN-1:0] memResult,
    input  logic [XLEN-1:0] wbResult,
    output logic [XLEN-1:0] result,
    output logic [XLEN-1:0] memWriteData
);

    logic [XLEN-1:0] aluA;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] rs2Value;
    logic [4:0]      shamt;

    function automatic logic [XLEN-1:0] forwardValue(
        input fwdSrc_t         sel,
        input logic [XLEN-1:0] regValue,
        input logic [XLEN-1:0] fromMem,
        input logic [XLEN-1:0] fromWb
    );
        case (sel)
            FWD_MEM: return fromMem;
            FWD_WB:  return fromWb;
            default: return regValue;
        endcase
    endfunction

    assign aluA     = forwardValue(fwdA, operandA, memResult, wbResult);
    assign rs2Value = forwardValue(fwdB, storeData, memResult, wbResult);

    // Immediate ops, loads and stores take B from decode
    assign aluB         = useImm ? operandB : rs2Value;
    assign memWriteData = rs2Value;
    assign shamt        = aluB[4:0];

    always_comb begin
        case (aluOp)
            ALU_SUB:  result = aluA - aluB;
            ALU_AND:  result = aluA & aluB;
            ALU_OR:   result = aluA | aluB;
            ALU_XOR:  result = aluA ^ aluB;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(aluA) < $signed(aluB)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, aluA < aluB};
            ALU_SLL:  result = aluA << shamt;
            ALU_SRL:  result = aluA >> shamt;
            ALU_SRA:  result = $unsigned($signed(aluA) >>> shamt);
            // Add also forms load and store addresses
            default:  result = aluA + aluB;
        endcase
    end

endmodule

// File: source/fetchStage.sv
// Program counter
`timescale 1ns/1ns

module fetchStage import corePkg::*; #(
    parameter logic [XLEN-1:0] ResetPc = '0
) (
    input  logic            clk,
    input  logic            arstN,
    input  logic            stall,
    output logic [XLEN-1:0] pc,
    output logic            fetchValid
);

    // One warm-up cycle after reset release
    // PC waits there until the valid flag is up
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchValid <= 1'b0;
        end else begin
            fetchValid <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= ResetPc;
        end else if (fetchValid && !stall) begin
            pc <= pc + XLEN'(4);
        end
    end

endmodule

// File: source/hazardUnit.sv
// Forwarding and load-use detection
`timescale 1ns/1ns

module hazardUnit import corePkg::*; (
    input  logic [REG_ADR_W-1:0] rs1Adr,
    input  logic [REG_ADR_W-1:0] rs2Adr,
    input  logic [REG_ADR_W-1:0] exRdAdr,
    input  logic                 exRegWrite,
    input  logic                 exMemEn,
    input  logic                 exMemWriteEn,
    input  logic [REG_ADR_W-1:0] memRdAdr,
    input  logic                 memRegWrite,
    output fwdSrc_t              fwdA,
    output fwdSrc_t              fwdB,
    output logic                 stall
);

    logic exLoad;

    // Selects are registered with the decode instruction, so the producer
    // in compute now sits in memory then, and memory moves to writeback
    function automatic fwdSrc_t pickSource(
        input logic [REG_ADR_W-1:0] srcAdr,
        input logic [REG_ADR_W-1:0] nearAdr,
        input logic                 nearWrite,
        input logic [REG_ADR_W-1:0] farAdr,
        input logic                 farWrite
    );
        if (nearWrite && nearAdr == srcAdr) begin
            return FWD_MEM;
        end else if (farWrite && farAdr == srcAdr) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwdA = pickSource(rs1Adr, exRdAdr, exRegWrite, memRdAdr, memRegWrite);
    assign fwdB = pickSource(rs2Adr, exRdAdr, exRegWrite, memRdAdr, memRegWrite);

    // Load data only exists in the memory stage
    assign exLoad = exMemEn && !exMemWriteEn;
    assign stall  = exLoad && exRegWrite && (exRdAdr == rs1Adr || exRdAdr == rs2Adr);

endmodule

// File: source/regFile.sv
// Integer register file
`timescale 1ns/1ns

module regFile import corePkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [REG_ADR_W-1:0] rs1Adr,
    input  logic [REG_ADR_W-1:0] rs2Adr,
    output logic [XLEN-1:0]      rs1Data,
    output logic [XLEN-1:0]      rs2Data,
    input  logic                 writeEn,
    input  logic [REG_ADR_W-1:0] writeAdr,
    input  logic [XLEN-1:0]      writeData
);

    logic [XLEN-1:0] regs [2**REG_ADR_W];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < 2**REG_ADR_W; k++) begin
                regs[k] <= '0;
            end
        end else if (writeEn) begin
            regs[writeAdr] <= writeData;
        end
    end

    // Same-cycle write shows up on the read ports
    // x0 stays zero since decode never writes it
    assign rs1Data = (writeEn && writeAdr == rs1Adr) ? writeData : regs[rs1Adr];
    assign rs2Data = (writeEn && writeAdr == rs2Adr) ? writeData : regs[rs2Adr];

    // Decode must have dropped every write to x0
    noWriteToZero: assert property (
        @(posedge clk) disable iff (!arstN)
        !(writeEn && writeAdr == '0)
    ) else $error("regFile: write to x0");

endmodule

// File: src.f
source/corePkg.sv
source/fetchStage.sv
source/regFile.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/computeCore.sv
tests/clockGen.sv
tests/coreTb.sv

// File: tests/clockGen.sv
// Testbench clock and reset
`timescale 1ns/1ns

module clockGen #(
    parameter int Period      = 40,
    parameter int ResetCycles = 4
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        arstN <= 1'b1;
    end

endmodule

// File: tests/coreTb.sv
// Core testbench
`timescale 1ns/1ns

module coreTb;

    localparam logic [31:0] ResetPc   = 32'h0000_0100;
    localparam int          ImemWords = 128;
    localparam int          DmemWords = 1024;
    localparam logic [31:0] Nop       = 32'h0000_0013;

    // ISA encodings
    localparam logic [6:0] OpReg   = 7'b0110011;
    localparam logic [6:0] OpImm   = 7'b0010011;
    localparam logic [6:0] OpLoad  = 7'b0000011;
    localparam logic [6:0] OpStore = 7'b0100011;
    localparam int         Base    = 0;
    localparam int         Alt     = 32;
    localparam int         FnAdd   = 0;
    localparam int         FnSll   = 1;
    localparam int         FnSlt   = 2;
    localparam int         FnSltu  = 3;
    localparam int         FnXor   = 4;
    localparam int         FnSrl   = 5;
    localparam int         FnOr    = 6;
    localparam int         FnAnd   = 7;

    logic        clk;
    logic        arstN;
    logic [31:0] extPc;
    logic [31:0] extInstr;
    logic        extMemEn;
    logic        extMemWriteEn;
    logic [31:0] extMemAdr;
    logic [31:0] extMemWriteData;
    logic [31:0] extMemReadData;
    logic [31:0] pcOffset;

    logic [31:0] instrMem [ImemWords];
    logic [31:0] dataMem [DmemWords];
    logic [31:0] prog [$];
    logic [31:0] expAdr [$];
    logic [31:0] expData [$];
    logic [31:0] endPc;
    int          seed;
    int          storeCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    clockGen #(.Period(40), .ResetCycles(4)) clocks (.clk, .arstN);

    computeCore #(.ResetPc(ResetPc)) dut_i (
        .clk, .arstN,
        .extPc, .extInstr,
        .extMemEn, .extMemWriteEn, .extMemAdr, .extMemWriteData, .extMemReadData
    );

    // Instruction memory returns NOP outside the program
    assign pcOffset = extPc - ResetPc;
    assign extInstr = (pcOffset < 32'(4 * ImemWords)) ? instrMem[pcOffset[8:2]] : Nop;

    // Data memory with a combinational read
    assign extMemReadData = extMemEn ? dataMem[extMemAdr[11:2]] : 32'h0;

    initial begin
        seed = 93106;
        for (int k = 0; k < DmemWords; k++) begin
            dataMem[k[9:0]] = $random(seed);
        end
        forever begin
            @(posedge clk);
            if (arstN && extMemEn && extMemWriteEn) begin
                dataMem[extMemAdr[11:2]] <= extMemWriteData;
            end
        end
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h",
                              name, actual, expected));
        end
    endtask

    task automatic checkResetState();
        checkValue("extPc", extPc, ResetPc);
        checkValue("extMemEn", 32'(extMemEn), 32'h0);
        checkValue("extMemWriteEn", 32'(extMemWriteEn), 32'h0);
    endtask

    task automatic regOp(input int funct7, input int funct3, input int rd,
                         input int rs1, input int rs2);
        prog.push_back({funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], OpReg});
    endtask

    task automatic immOp(input int funct3, input int rd, input int rs1, input int imm);
        prog.push_back({imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], OpImm});
    endtask

    task automatic loadOp(input int rd, input int rs1, input int imm);
        prog.push_back({imm[11:0], rs1[4:0], 3'b010, rd[4:0], OpLoad});
    endtask

    // Store word plus the address and data it must put on the port
    task automatic storeOp(input int rs2, input int rs1, input int imm,
                           input logic [31:0] adr, input logic [31:0] data);
        prog.push_back({imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OpStore});
        expAdr.push_back(adr);
        expData.push_back(data);
    endtask

    task automatic nops(input int count);
        repeat (count) prog.push_back(Nop);
    endtask

    task automatic buildProgram();
        // x10 base, x1 = -7, x2 = 5, x3 = -1792, x4 = 37, x5 = 0x5A5
        immOp(FnAdd, 10, 0, 32'h200);
        immOp(FnAdd, 1, 0, -7);
        immOp(FnAdd, 2, 0, 5);
        immOp(FnAdd, 3, 0, -1792);
        immOp(FnAdd, 4, 0, 37);
        immOp(FnAdd, 5, 0, 32'h5A5);

        regOp(Base, FnAdd, 20, 1, 2);
        storeOp(20, 10, 32'h00, 32'h0000_0200, 32'hFFFF_FFFE);
        regOp(Alt, FnAdd, 20, 1, 2);
        storeOp(20, 10, 32'h04, 32'h0000_0204, 32'hFFFF_FFF4);
        regOp(Base, FnAnd, 20, 1, 2);
        storeOp(20, 10, 32'h08, 32'h0000_0208, 32'h0000_0001);
        regOp(Base, FnOr, 20, 1, 2);
        storeOp(20, 10, 32'h0C, 32'h0000_020C, 32'hFFFF_FFFD);
        regOp(Base, FnXor, 20, 1, 2);
        storeOp(20, 10, 32'h10, 32'h0000_0210, 32'hFFFF_FFFC);
        regOp(Base, FnSlt, 20, 1, 2);
        storeOp(20, 10, 32'h14, 32'h0000_0214, 32'h0000_0001);
        regOp(Base, FnSltu, 20, 1, 2);
        storeOp(20, 10, 32'h18, 32'h0000_0218, 32'h0000_0000);
        // Shift amount 37 uses only its low five bits
        regOp(Base, FnSll, 20, 3, 4);
        storeOp(20, 10, 32'h1C, 32'h0000_021C, 32'hFFFF_2000);
        regOp(Base, FnSrl, 20, 3, 4);
        storeOp(20, 10, 32'h20, 32'h0000_0220, 32'h07FF_FFC8);
        regOp(Alt, FnSrl, 20, 3, 4);
        storeOp(20, 10, 32'h24, 32'h0000_0224, 32'hFFFF_FFC8);

        immOp(FnAdd, 20, 1, 100);
        storeOp(20, 10, 32'h28, 32'h0000_0228, 32'h0000_005D);
        immOp(FnAnd, 20, 5, -16);
        storeOp(20, 10, 32'h2C, 32'h0000_022C, 32'h0000_05A0);
        immOp(FnOr, 20, 5, -2048);
        storeOp(20, 10, 32'h30, 32'h0000_0230, 32'hFFFF_FDA5);
        immOp(FnXor, 20, 5, -1);
        storeOp(20, 10, 32'h34, 32'h0000_0234, 32'hFFFF_FA5A);
        // 5 < -1 is false as a signed compare
        immOp(FnSlt, 20, 2, -1);
        storeOp(20, 10, 32'h38, 32'h0000_0238, 32'h0000_0000);
        immOp(FnSlt, 20, 1, -6);
        storeOp(20, 10, 32'h3C, 32'h0000_023C, 32'h0000_0001);

        // Dependency at distance 1, 2 and 3, then an independent pair
        immOp(FnAdd, 6, 0, 11);
        regOp(Base, FnAdd, 7, 6, 6);
        storeOp(7, 10, 32'h40, 32'h0000_0240, 32'h0000_0016);
        immOp(FnAdd, 8, 0, 13);
        nops(1);
        regOp(Base, FnAdd, 9, 8, 8);
        nops(1);
        storeOp(9, 10, 32'h44, 32'h0000_0244, 32'h0000_001A);
        immOp(FnAdd, 11, 0, 17);
        nops(2);
        regOp(Base, FnAdd, 12, 11, 11);
        nops(2);
        storeOp(12, 10, 32'h48, 32'h0000_0248, 32'h0000_0022);
        immOp(FnAdd, 13, 0, 11);
        nops(3);
        regOp(Base, FnAdd, 14, 13, 13);
        nops(3);
        storeOp(14, 10, 32'h4C, 32'h0000_024C, 32'h0000_0016);
        // Newest producer wins
        immOp(FnAdd, 16, 0, 1);
        immOp(FnAdd, 16, 0, 2);
        regOp(Base, FnAdd, 17, 16, 16);
        storeOp(17, 10, 32'h50, 32'h0000_0250, 32'h0000_0004);
        // Store base address taken from forwarding
        immOp(FnAdd, 15, 10, 32'h60);
        storeOp(17, 15, 0, 32'h0000_0260, 32'h0000_0004);

        // Load-use on an ALU operand and on store data
        immOp(FnAdd, 18, 0, 32'h321);
        storeOp(18, 10, 32'h80, 32'h0000_0280, 32'h0000_0321);
        loadOp(19, 10, 32'h80);
        regOp(Base, FnAdd, 21, 19, 2);
        storeOp(21, 10, 32'h84, 32'h0000_0284, 32'h0000_0326);
        loadOp(22, 10, 32'h84);
        storeOp(22, 10, 32'h88, 32'h0000_0288, 32'h0000_0326);

        // Writes to x0 are dropped
        immOp(FnAdd, 0, 0, 32'h55);
        storeOp(0, 10, 32'h8C, 32'h0000_028C, 32'h0000_0000);
        regOp(Base, FnAdd, 0, 1, 2);
        storeOp(0, 10, 32'h90, 32'h0000_0290, 32'h0000_0000);

        // Negative and large offsets
        storeOp(2, 10, -4, 32'h0000_01FC, 32'h0000_0005);
        storeOp(2, 10, -496, 32'h0000_0010, 32'h0000_0005);
        storeOp(1, 10, 32'h7FC, 32'h0000_09FC, 32'hFFFF_FFF9);
    endtask

    // Store checker on the data port
    always @(negedge clk) begin
        if (arstN && extMemEn) begin
            if (extMemAdr >= 32'(4 * DmemWords)) begin
                failRun("Data access outside the data memory");
            end else if (extMemWriteEn) begin
                if (storeCount >= expAdr.size()) begin
                    failRun("More stores reached the data port than the program makes");
                end else begin
                    checkValue($sformatf("extMemAdr (store %0d)", storeCount),
                               extMemAdr, expAdr[storeCount]);
                    checkValue($sformatf("extMemWriteData (store %0d)", storeCount),
                               extMemWriteData, expData[storeCount]);
                    storeCount++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            failRun($sformatf("Timeout after %0d cycles, program did not finish", cycleCount));
        end
    end

    initial begin
        buildProgram();
        for (int k = 0; k < ImemWords; k++) begin
            instrMem[k[6:0]] = (k < prog.size()) ? prog[k] : Nop;
        end
        cycleLimit = 4 * prog.size() + 20;
        endPc = ResetPc + 32'(4 * (prog.size() + 6));

        // During reset and the first cycle after release
        @(posedge clk);
        @(negedge clk);
        while (!arstN) begin
            checkResetState();
            @(negedge clk);
        end
        checkResetState();

        // Last instruction has left writeback once the PC is this far on
        while (extPc < endPc) begin
            @(negedge clk);
        end
        if (storeCount != expAdr.size()) begin
            failRun($sformatf("Only %0d of %0d stores reached the data port",
                              storeCount, expAdr.size()));
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule
